/* Makefile */
SIM    := verilator
FLAGS  := --binary --timing --assert
TOP    := mmio_tb
FLIST  := build.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := run.log
SRCS   := $(shell grep -v '^+' $(FLIST))
HDRS   := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* build.f */
+incdir+include
hdl/mmio_pkg.sv
hdl/data_ram.sv
hdl/collision_unit.sv
hdl/mmio_decode.sv
hdl/mmio_readback.sv
hdl/mmio_top.sv
dv/mmio_tb.sv

/* dv/mmio_patterns.txt */
# op addr data, hex. W writes data, R expects data on data_out one cycle later
# window addr = 1000 + unit*80 + reg*4, unit 0c is player 0, stage (100,100) 200x150
W 1600 00960096
R 1600 00960096
R 1680 00000000
W 1684 00640064
W 168C 00C80096
R 1604 00640064
R 160C 00C80096
W 1608 0014001E
R 1610 00000001
W 1680 00320096
W 1688 0014001E
R 1690 00000002
W 1600 01220096
R 1610 00000005
W 1680 00960050
R 1690 00000009
W 1600 01900014
W 1608 000A000A
R 1610 0000000C
W 1700 12345678
W 1704 0BADF00D
R 1700 00000000
R 1704 00000000
R 1604 00640064
R 1600 01900014

/* include/mmio_tb_checks.svh */
`ifndef MMIO_TB_CHECKS_SVH
`define MMIO_TB_CHECKS_SVH

// First error ends the run
task automatic stop_with_failure();
	$display("Result: FAILED");
	$fatal(1, "simulation stopped at first error");
endtask

// Full bus word compare
task automatic check_word(input string name, input logic [mmio_pkg::DATA_W-1:0] exp,
		input logic [mmio_pkg::DATA_W-1:0] act);
	if (act !== exp) begin
		$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
		stop_with_failure();
	end
endtask

// Contact flags with above in the msb
task automatic check_contact(input string name, input mmio_pkg::contact_t exp,
		input mmio_pkg::contact_t act);
	if (act !== exp) begin
		$display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
		stop_with_failure();
	end
endtask

// Polls on the falling edge so data_out still holds its reset value on exit
task automatic wait_reset_release(input int limit);
	int n;
	n = 0;
	while (rst_n !== 1'b1) begin
		if (n >= limit) begin
			$display("Timeout: reset still asserted after %0d cycles", limit);
			stop_with_failure();
		end
		@(negedge clock);
		n++;
	end
endtask

`endif

/* dv/mmio_tb.sv */
`timescale 1ns/1ps

module mmio_tb;

	localparam int NUM_PLAYERS = 2;   // mmio_top defaults
	localparam int RAM_AW      = 8;
	localparam int RESET_LIMIT = 40;  // Cycles
	localparam int PAT_LIMIT   = 400; // Bus cycles for the pattern file
	localparam int AW          = mmio_pkg::ADDR_W;
	localparam int DW          = mmio_pkg::DATA_W;
	localparam int UW          = mmio_pkg::UNIT_W;
	localparam int RW          = mmio_pkg::REG_W;

	logic          clock;
	logic          rst_n;
	logic [AW-1:0] address;
	logic [DW-1:0] data_in;
	logic          wren;
	logic [DW-1:0] data_out;

	int            bus_cycles;
	logic [31:0]   rng;
	logic [DW-1:0] ram_sh [0:(1<<RAM_AW)-1]; // Last word written per RAM address
	logic [DW-1:0] pos_sh [NUM_PLAYERS];
	logic [DW-1:0] size_sh [NUM_PLAYERS];
	logic [DW-1:0] stage_pos_sh;
	logic [DW-1:0] stage_size_sh;

	`include "mmio_tb_checks.svh"

	mmio_top dut_i (
		.clock    (clock),
		.rst_n    (rst_n),
		.address  (address),
		.data_in  (data_in),
		.wren     (wren),
		.data_out (data_out)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	initial begin
		rst_n   = 1'b0;
		address = '0;
		data_in = '0;
		wren    = 1'b0;
		repeat (10) @(posedge clock);
		rst_n <= 1'b1;
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Contact flags from the box rule with 17 bit edges that never wrap
	function automatic mmio_pkg::contact_t expected_contact(input logic [DW-1:0] p,
			input logic [DW-1:0] ps, input logic [DW-1:0] s, input logic [DW-1:0] ss);
		mmio_pkg::contact_t c;
		logic [16:0] pl, pt, pr, pb, sl, st, sr, sb;
		pl = {1'b0, p[31:16]};
		pt = {1'b0, p[15:0]};
		pr = pl + {1'b0, ps[31:16]}; // Right edge is x plus width
		pb = pt + {1'b0, ps[15:0]};
		sl = {1'b0, s[31:16]};
		st = {1'b0, s[15:0]};
		sr = sl + {1'b0, ss[31:16]};
		sb = st + {1'b0, ss[15:0]};
		c.overlap  = (pl < sr) && (sl < pr) && (pt < sb) && (st < pb);
		c.left_of  = pl < sl;
		c.right_of = pr > sr;
		c.above    = pt < st;
		return c;
	endfunction

	function automatic logic [AW-1:0] window_addr(input int u, input int r);
		logic [AW-1:0] a;
		a = '0;
		a[mmio_pkg::RAM_SEL_BIT] = 1'b1;
		a[mmio_pkg::UNIT_LSB +: UW] = UW'(mmio_pkg::COLL_BASE + u);
		a[mmio_pkg::REG_LSB +: RW]  = RW'(r);
		return a;
	endfunction

	// Player index for a window address or -1 for RAM and dead units
	function automatic int unit_index(input logic [AW-1:0] a);
		int u;
		u = int'(a[mmio_pkg::UNIT_LSB +: UW]) - mmio_pkg::COLL_BASE;
		if (!a[mmio_pkg::RAM_SEL_BIT] || u < 0 || u >= NUM_PLAYERS) begin
			u = -1;
		end
		return u;
	endfunction

	task automatic write_bus(input logic [AW-1:0] a, input logic [DW-1:0] d);
		@(posedge clock);
		address <= a;
		data_in <= d;
		wren    <= 1'b1; // Taken on the next edge
		bus_cycles++;
	endtask

	task automatic read_bus(input logic [AW-1:0] a, output logic [DW-1:0] q);
		@(posedge clock);
		address <= a;
		data_in <= '0;
		wren    <= 1'b0;
		@(posedge clock);  // Word registered here
		@(negedge clock);
		q = data_out;
		bus_cycles += 2;
	endtask

	// Expected register state after each write
	task automatic track_write(input logic [AW-1:0] a, input logic [DW-1:0] d);
		int u;
		u = unit_index(a);
		if (u >= 0) begin
			case (mmio_pkg::coll_reg_e'(a[mmio_pkg::REG_LSB +: RW]))
				mmio_pkg::REG_PLAYER_POS:  pos_sh[u]     = d;
				mmio_pkg::REG_PLAYER_SIZE: size_sh[u]    = d;
				mmio_pkg::REG_STAGE_POS:   stage_pos_sh  = d;
				mmio_pkg::REG_STAGE_SIZE:  stage_size_sh = d;
				default: ;
			endcase
		end
	endtask

	task automatic run_patterns();
		int            fd;
		int            rc;
		int            start;
		int            u;
		string         line;
		logic [7:0]    op;
		logic [AW-1:0] a;
		logic [DW-1:0] d;
		logic [DW-1:0] got;
		fd = $fopen("dv/mmio_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file dv/mmio_patterns.txt");
			stop_with_failure();
		end
		start = bus_cycles;
		while (!$feof(fd)) begin
			if (bus_cycles - start > PAT_LIMIT) begin
				$display("Timeout: pattern file ran past %0d bus cycles", PAT_LIMIT);
				stop_with_failure();
			end
			line = "";
			rc   = $fgets(line, fd);
			rc   = $sscanf(line, "%s %h %h", op, a, d); // Comment lines give rc < 3
			if (rc == 3 && op == "W") begin
				write_bus(a, d);
				track_write(a, d);
			end else if (rc == 3 && op == "R") begin
				read_bus(a, got);
				check_word("data_out", d, got);
				u = unit_index(a);
				if (u >= 0 && a[mmio_pkg::REG_LSB +: RW] == mmio_pkg::REG_CONTACT) begin
					check_contact("contact", expected_contact(pos_sh[u], size_sh[u],
						stage_pos_sh, stage_size_sh), got[3:0]);
				end
			end
		end
		$fclose(fd);
	endtask

	initial begin
		logic [DW-1:0]     got;
		logic [RAM_AW-1:0] ra;
		logic [RAM_AW-1:0] ra_q [$];
		int                n;
		int                u;
		int                r;
		bus_cycles    = 0;
		rng           = 32'h8794;
		stage_pos_sh  = '0;
		stage_size_sh = '0;
		for (u = 0; u < NUM_PLAYERS; u++) begin
			pos_sh[u]  = '0;
			size_sh[u] = '0;
		end
		wait_reset_release(RESET_LIMIT);
		check_word("data_out", '0, data_out); // Reset value
		for (u = 0; u < NUM_PLAYERS; u++) begin
			for (r = 0; r <= int'(mmio_pkg::REG_CONTACT); r++) begin
				read_bus(window_addr(u, r), got);
				check_word("data_out", '0, got);
			end
		end
		// Random RAM traffic with repeated addresses allowed
		for (n = 0; n < 32; n++) begin
			rng = next_random(rng);
			ra  = rng[RAM_AW-1:0];
			rng = next_random(rng);
			write_bus(AW'(ra), rng);
			ram_sh[ra] = rng;
			ra_q.push_back(ra);
		end
		while (ra_q.size() > 0) begin
			ra = ra_q.pop_front();
			read_bus(AW'(ra), got);
			check_word("data_out", ram_sh[ra], got);
		end
		run_patterns();
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* hdl/collision_unit.sv */
`timescale 1ns/1ps

module collision_unit (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        we,
	input  mmio_pkg::coll_reg_e         reg_sel,
	input  logic [mmio_pkg::DATA_W-1:0] wdata,
	input  logic [mmio_pkg::DATA_W-1:0] stage_pos,
	input  logic [mmio_pkg::DATA_W-1:0] stage_size,
	output logic [mmio_pkg::DATA_W-1:0] player_pos,
	output logic [mmio_pkg::DATA_W-1:0] player_size,
	output mmio_pkg::contact_t          contact
);

	localparam int CW = mmio_pkg::COORD_W;

	logic [CW-1:0] px, py, pw, ph; // Player box
	logic [CW-1:0] sx, sy, sw, sh; // Stage box
	logic [CW:0]   p_right, p_bottom;
	logic [CW:0]   s_right, s_bottom;

	// Player registers, written through this unit's window only
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			player_pos  <= '0;
			player_size <= '0;
		end else if (we) begin
			case (reg_sel)
				mmio_pkg::REG_PLAYER_POS:  player_pos  <= wdata;
				mmio_pkg::REG_PLAYER_SIZE: player_size <= wdata;
				default: ;
			endcase
		end
	end

	// Unpack x high, y low
	assign px = player_pos[mmio_pkg::DATA_W-1 -: CW];
	assign py = player_pos[CW-1:0];
	assign pw = player_size[mmio_pkg::DATA_W-1 -: CW];
	assign ph = player_size[CW-1:0];
	assign sx = stage_pos[mmio_pkg::DATA_W-1 -: CW];
	assign sy = stage_pos[CW-1:0];
	assign sw = stage_size[mmio_pkg::DATA_W-1 -: CW];
	assign sh = stage_size[CW-1:0];

	// Far edges with a carry bit so nothing wraps
	assign p_right  = {1'b0, px} + {1'b0, pw};
	assign p_bottom = {1'b0, py} + {1'b0, ph};
	assign s_right  = {1'b0, sx} + {1'b0, sw};
	assign s_bottom = {1'b0, sy} + {1'b0, sh};

	// Half-open boxes, both axes must intersect
	always_comb begin
		contact.overlap  = ({1'b0, px} < s_right) && ({1'b0, sx} < p_right) &&
			({1'b0, py} < s_bottom) && ({1'b0, sy} < p_bottom);
		contact.left_of  = px < sx;
		contact.right_of = p_right > s_right;
		contact.above    = py < sy;
	end

	// A box no wider than the stage cannot stick out on both sides
	a_not_both_sides: assert property (@(posedge clock) disable iff (!rst_n)
		(pw <= sw) |-> !(contact.left_of && contact.right_of));

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
	parameter int RAM_AW = 8
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        we,
	input  logic [RAM_AW-1:0]           addr,
	input  logic [mmio_pkg::DATA_W-1:0] wdata,
	output logic [mmio_pkg::DATA_W-1:0] q
);

	logic [mmio_pkg::DATA_W-1:0] mem [0:(1<<RAM_AW)-1];

	// Rising edge write
	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			q <= '0;
		end else begin
			q <= mem[addr];
		end
	end

endmodule

/* hdl/mmio_decode.sv */
`timescale 1ns/1ps

module mmio_decode #(
	parameter int NUM_PLAYERS = 2,
	parameter int RAM_AW      = 8
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic [mmio_pkg::ADDR_W-1:0] address,
	input  logic [mmio_pkg::DATA_W-1:0] data_in,
	input  logic                        wren,
	output logic [NUM_PLAYERS-1:0]      unit_we,
	output mmio_pkg::coll_reg_e         reg_sel,
	output logic                        ram_we,
	output logic [RAM_AW-1:0]           ram_addr,
	output logic [mmio_pkg::DATA_W-1:0] stage_pos,
	output logic [mmio_pkg::DATA_W-1:0] stage_size,
	output logic [NUM_PLAYERS-1:0]      rd_unit_hit,
	output mmio_pkg::coll_reg_e         rd_reg,
	output logic                        rd_is_ram
);

	logic                        in_window;  // High for the coprocessor window
	logic [mmio_pkg::UNIT_W-1:0] unit_field;
	logic [mmio_pkg::REG_W-1:0]  reg_field;
	logic                        stage_we;   // Write through any live unit window

	// Address split
	assign in_window  = address[mmio_pkg::RAM_SEL_BIT];
	assign unit_field = address[mmio_pkg::UNIT_LSB +: mmio_pkg::UNIT_W];
	assign reg_field  = address[mmio_pkg::REG_LSB +: mmio_pkg::REG_W];

	// RAM word address from the low bits
	assign rd_is_ram = ~in_window;
	assign ram_we    = wren & ~in_window;
	assign ram_addr  = address[RAM_AW-1:0];

	// Same register index for write and read paths
	assign reg_sel = mmio_pkg::coll_reg_e'(reg_field);
	assign rd_reg  = mmio_pkg::coll_reg_e'(reg_field);

	// Unit match against COLL_BASE + i
	genvar i;
	generate
		for (i = 0; i < NUM_PLAYERS; i++) begin : g_hit
			assign rd_unit_hit[i] = in_window &&
				(int'(unit_field) == mmio_pkg::COLL_BASE + i);
		end
	endgenerate

	assign unit_we  = rd_unit_hit & {NUM_PLAYERS{wren}}; // Out of range units get nothing
	assign stage_we = wren & (|rd_unit_hit);

	// Stage rectangle shared by every collision unit
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			stage_pos  <= '0;
			stage_size <= '0;
		end else if (stage_we) begin
			case (reg_sel)
				mmio_pkg::REG_STAGE_POS:  stage_pos  <= data_in;
				mmio_pkg::REG_STAGE_SIZE: stage_size <= data_in;
				default: ;                // Player regs live in the units
			endcase
		end
	end

	// At most one unit takes a write
	a_unit_we_onehot: assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0(unit_we));

endmodule

/* hdl/mmio_pkg.sv */
package mmio_pkg;

	// CPU bus
	localparam int ADDR_W      = 13;
	localparam int DATA_W      = 32;
	localparam int RAM_SEL_BIT = 12; // High selects the coprocessor window

	// Window address fields
	localparam int UNIT_LSB = 7;
	localparam int UNIT_W   = 5;  // Unit number in bits 11:7
	localparam int REG_LSB  = 2;
	localparam int REG_W    = 5;  // Register index in bits 6:2

	// Player 0 collision unit, player i at COLL_BASE + i
	localparam int COLL_BASE = 12;

	// One coordinate, x in upper half of a packed word
	localparam int COORD_W = 16;

	// Contact result, overlap in bit 0
	typedef struct packed {
		logic above;    // Player top above stage top
		logic right_of; // Player right edge past stage right edge
		logic left_of;  // Player left edge before stage left edge
		logic overlap;
	} contact_t;

	// Registers inside a collision unit window
	typedef enum logic [REG_W-1:0] {
		REG_PLAYER_POS  = 5'd0,
		REG_STAGE_POS   = 5'd1, // Shared by all units
		REG_PLAYER_SIZE = 5'd2,
		REG_STAGE_SIZE  = 5'd3, // Shared by all units
		REG_CONTACT     = 5'd4  // Read only
	} coll_reg_e;

endpackage

/* hdl/mmio_readback.sv */
`timescale 1ns/1ps

module mmio_readback #(
	parameter int NUM_PLAYERS = 2
) (
	input  logic                                          clock,
	input  logic                                          rst_n,
	input  logic [NUM_PLAYERS-1:0]                        rd_unit_hit,
	input  mmio_pkg::coll_reg_e                           rd_reg,
	input  logic                                          rd_is_ram,
	input  logic [mmio_pkg::DATA_W-1:0]                   stage_pos,
	input  logic [mmio_pkg::DATA_W-1:0]                   stage_size,
	input  logic [NUM_PLAYERS-1:0][mmio_pkg::DATA_W-1:0] player_pos,
	input  logic [NUM_PLAYERS-1:0][mmio_pkg::DATA_W-1:0] player_size,
	input  mmio_pkg::contact_t [NUM_PLAYERS-1:0]          contact,
	input  logic [mmio_pkg::DATA_W-1:0]                   ram_q,
	output logic [mmio_pkg::DATA_W-1:0]                   data_out
);

	localparam int CONTACT_W = $bits(mmio_pkg::contact_t);

	logic [mmio_pkg::DATA_W-1:0] unit_word; // Selected window word
	logic [mmio_pkg::DATA_W-1:0] word_q;
	logic                        ram_sel_q; // Select delayed to meet RAM q

	always_comb begin
		unit_word = '0;                 // No hit reads as zero
		for (int i = 0; i < NUM_PLAYERS; i++) begin
			if (rd_unit_hit[i]) begin
				case (rd_reg)
					mmio_pkg::REG_PLAYER_POS:  unit_word = player_pos[i];
					mmio_pkg::REG_STAGE_POS:   unit_word = stage_pos;
					mmio_pkg::REG_PLAYER_SIZE: unit_word = player_size[i];
					mmio_pkg::REG_STAGE_SIZE:  unit_word = stage_size;
					mmio_pkg::REG_CONTACT:
						unit_word = {{(mmio_pkg::DATA_W-CONTACT_W){1'b0}}, contact[i]};
					default: unit_word = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			word_q    <= '0;
			ram_sel_q <= 1'b0;
		end else begin
			word_q    <= rd_is_ram ? '0 : unit_word;
			ram_sel_q <= rd_is_ram;
		end
	end

	assign data_out = ram_sel_q ? ram_q : word_q; // Both legs already registered

	a_hit_onehot: assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0(rd_unit_hit));

endmodule

/* hdl/mmio_top.sv */
`timescale 1ns/1ps

module mmio_top #(
	parameter int NUM_PLAYERS = 2,
	parameter int RAM_AW      = 8  // RAM word address bits
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic [mmio_pkg::ADDR_W-1:0] address,
	input  logic [mmio_pkg::DATA_W-1:0] data_in,
	input  logic                        wren,
	output logic [mmio_pkg::DATA_W-1:0] data_out
);

	// Decoder outputs
	logic [NUM_PLAYERS-1:0]      unit_we;
	logic [NUM_PLAYERS-1:0]      rd_unit_hit;
	mmio_pkg::coll_reg_e         reg_sel;
	mmio_pkg::coll_reg_e         rd_reg;
	logic                        ram_we;
	logic                        rd_is_ram;
	logic [RAM_AW-1:0]           ram_addr;
	logic [mmio_pkg::DATA_W-1:0] stage_pos;
	logic [mmio_pkg::DATA_W-1:0] stage_size;

	// Per player results into the read mux
	logic [NUM_PLAYERS-1:0][mmio_pkg::DATA_W-1:0] player_pos;
	logic [NUM_PLAYERS-1:0][mmio_pkg::DATA_W-1:0] player_size;
	mmio_pkg::contact_t [NUM_PLAYERS-1:0]          contact;
	logic [mmio_pkg::DATA_W-1:0]                   ram_q;

	mmio_decode #(
		.NUM_PLAYERS (NUM_PLAYERS),
		.RAM_AW      (RAM_AW)
	) decode_i (
		.clock       (clock),
		.rst_n       (rst_n),
		.address     (address),
		.data_in     (data_in),
		.wren        (wren),
		.unit_we     (unit_we),
		.reg_sel     (reg_sel),
		.ram_we      (ram_we),
		.ram_addr    (ram_addr),
		.stage_pos   (stage_pos),
		.stage_size  (stage_size),
		.rd_unit_hit (rd_unit_hit),
		.rd_reg      (rd_reg),
		.rd_is_ram   (rd_is_ram)
	);

	// One collision unit per player
	for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_coll
		collision_unit coll_i (
			.clock       (clock),
			.rst_n       (rst_n),
			.we          (unit_we[i]),
			.reg_sel     (reg_sel),
			.wdata       (data_in),
			.stage_pos   (stage_pos),
			.stage_size  (stage_size),
			.player_pos  (player_pos[i]),
			.player_size (player_size[i]),
			.contact     (contact[i])
		);
	end

	mmio_readback #(
		.NUM_PLAYERS (NUM_PLAYERS)
	) readback_i (
		.clock       (clock),
		.rst_n       (rst_n),
		.rd_unit_hit (rd_unit_hit),
		.rd_reg      (rd_reg),
		.rd_is_ram   (rd_is_ram),
		.stage_pos   (stage_pos),
		.stage_size  (stage_size),
		.player_pos  (player_pos),
		.player_size (player_size),
		.contact     (contact),
		.ram_q       (ram_q),
		.data_out    (data_out)
	);

	data_ram #(
		.RAM_AW (RAM_AW)
	) ram_i (
		.clock (clock),
		.rst_n (rst_n),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (data_in),
		.q     (ram_q)
	);

endmodule
